/* verilog.f */
+incdir+.
snn_pkg.sv
organize_data_unit.sv
line_ring_buffer.sv
spike_window_conv.sv
conv_layer_ctrl.sv
snn_conv_top.sv
tb_clk_gen.sv
tb_snn_conv.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_snn_conv -f verilog.f -o sim

./obj_dir/sim | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "Simulation passed."
    exit 0
else
    echo "Simulation failed, see sim.log."
    exit 1
fi

/* tb_snn_conv.sv */
// Testbench for snn_conv_top; drives frames and commands and checks every partial sum against a model.
`timescale 1ns/1ps
`default_nettype none
`include "snn_params.svh"

module tb_snn_conv
    import snn_pkg::*;
();

    localparam int TOTAL_PIX   = 809;                        // Pixels over all tests.
    localparam int WATCHDOG_NS = TOTAL_PIX * 4 * 10 + 4000;

    logic                           s_clk;
    logic                           s_rst;
    logic                           rst_req;
    logic                           code_valid;
    code_op_e                       code_op;
    logic [15:0]                    code_arg;
    spike_t                         spikes_in;
    logic                           spikes_valid;
    logic                           psum_valid;
    logic [`TIME_STEPS*`PSUM_W-1:0] psum;
    size_t                          out_row;
    size_t                          out_col;
    logic                           frame_done;

    integer      seed = 50;
    spike_t      frm [0:15][0:15];     // Frame under test, row then column.
    weight_t     wts [0:8];
    int          last_cyc [0:15];      // Cycle count when each line's last pixel was driven.
    int unsigned cyc = 0;
    int          cur_w = 16;
    int          cur_h = 8;
    int          out_base = 0;
    int          done_base = 0;
    int          n_total = 0;
    int          n_done = 0;
    int          errors = 0;
    int          checks = 0;
    int          n_tests = 0;
    int          err_base;
    int          test_out_base;
    string       test_name = "startup";
    logic        uniform_chk = 1'b0;   // Every sum of the frame must also equal uniform_exp.
    psum_t       uniform_exp = '0;

    tb_clk_gen clk_gen_i (
        .i_rst_req (rst_req),
        .o_clk     (s_clk),
        .o_rst     (s_rst)
    );

    snn_conv_top snn_conv_top_i (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_code_valid   (code_valid),
        .i_code_op      (code_op),
        .i_code_arg     (code_arg),
        .i_spikes_in    (spikes_in),
        .i_spikes_valid (spikes_valid),
        .o_psum_valid   (psum_valid),
        .o_psum         (psum),
        .o_out_row      (out_row),
        .o_out_col      (out_col),
        .o_frame_done   (frame_done)
    );

    always @(posedge s_clk) cyc <= cyc + 1;

    // Sum of the weights whose input pixel spiked in time step t, for the window at (r, c).
    function automatic psum_t ref_psum(input int r, input int c, input int t);
        int acc;
        acc = 0;
        for (int k = 0; k < 9; k++) begin
            if (frm[r + k / 3][c + k % 3][t]) begin
                acc = acc + int'(wts[k]);
            end
        end
        return psum_t'(acc);
    endfunction

    task automatic check_psum(input string what, input psum_t exp, input psum_t act);
        checks++;
        if (exp !== act) begin
            $display("ERR %s %s expected %0d actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_pos(input string what, input size_t exp, input size_t act);
        checks++;
        if (exp !== act) begin
            $display("ERR %s %s expected %0d actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            $display("ERR %s %s expected %b actual %b", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_cycle(input string what, input int exp, input int act);
        checks++;
        if (exp != act) begin
            $display("ERR %s %s expected cycle %0d actual cycle %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    // Outputs arrive in raster order, so the output count gives the expected position.
    always @(negedge s_clk) begin : monitor
        int idx;
        int r;
        int c;
        if (!s_rst && psum_valid) begin
            idx = n_total - out_base;
            r   = idx / (cur_w - 2);
            c   = idx % (cur_w - 2);
            if (r > cur_h - 3) begin
                $display("%s: an output came after the last window of the frame.", test_name);
                errors++;
            end else begin
                check_pos("row", size_t'(r), out_row);
                check_pos("col", size_t'(c), out_col);
                check_flag("frame_done", (r == cur_h - 3) && (c == cur_w - 3), frame_done);
                check_cycle("output timing", last_cyc[r + 2] + 3 + c, int'(cyc));
                for (int t = 0; t < `TIME_STEPS; t++) begin
                    check_psum($sformatf("psum r%0d c%0d t%0d", r, c, t), ref_psum(r, c, t),
                               psum_t'(psum[t*`PSUM_W +: `PSUM_W]));
                    if (uniform_chk) begin
                        check_psum($sformatf("uniform r%0d c%0d t%0d", r, c, t), uniform_exp,
                                   psum_t'(psum[t*`PSUM_W +: `PSUM_W]));
                    end
                end
            end
            n_total++;
            if (frame_done) n_done++;
        end else if (!s_rst && frame_done) begin
            $display("%s: o_frame_done was high without o_psum_valid.", test_name);
            errors++;
        end
    end

    task automatic send_cmd(input code_op_e op, input logic [15:0] arg);
        @(posedge s_clk);
        #1;
        code_valid = 1'b1;
        code_op    = op;
        code_arg   = arg;
        @(posedge s_clk);
        #1;
        code_valid = 1'b0;
    endtask

    task automatic configure(input int w, input int h);
        send_cmd(OP_SET_SIZE, {8'(h), 8'(w)});     // Height in the high byte.
    endtask

    task automatic set_weights(input bit rnd, input weight_t val);
        for (int k = 0; k < 9; k++) begin
            wts[k] = rnd ? weight_t'($random(seed)) : val;
            send_cmd(OP_SET_WEIGHT, {8'h00, 4'(k), wts[k]});
        end
    endtask

    task automatic fill_frame(input int w, input int h, input bit all_ones);
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < 16; c++) begin
                frm[r][c] = (c >= w) ? '0 : (all_ones ? '1 : spike_t'($random(seed)));
            end
        end
    endtask

    // With gaps, each pixel is preceded by up to 3 idle cycles.
    task automatic drive_lines(input int w, input int nlines, input bit gaps);
        int g;
        for (int r = 0; r < nlines; r++) begin
            for (int c = 0; c < w; c++) begin
                g = gaps ? ($random(seed) & 3) : 0;
                repeat (g) begin
                    @(posedge s_clk);
                    #1;
                    spikes_valid = 1'b0;
                end
                @(posedge s_clk);
                #1;
                spikes_valid = 1'b1;
                spikes_in    = frm[r][c];
                if (c == w - 1) last_cyc[r] = int'(cyc);
            end
        end
        @(posedge s_clk);
        #1;
        spikes_valid = 1'b0;
    endtask

    task automatic start_frame(input int w, input int h);
        cur_w     = w;
        cur_h     = h;
        out_base  = n_total;
        done_base = n_done;
    endtask

    task automatic run_frame(input int w, input int h, input bit gaps);
        start_frame(w, h);
        drive_lines(w, h, gaps);
        while (n_total - out_base < (w - 2) * (h - 2)) @(negedge s_clk);
        repeat (4) @(negedge s_clk);
        if (n_done - done_base != 1) begin
            $display("%s: o_frame_done rose %0d times in one frame instead of once.",
                     test_name, n_done - done_base);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        err_base      = errors;
        test_out_base = n_total;
        n_tests++;
    endtask

    task automatic end_test();
        $display("%-18s %0d outputs, %0d errors", test_name, n_total - test_out_base,
                 errors - err_base);
    endtask

    initial begin
        rst_req      = 1'b0;
        code_valid   = 1'b0;
        code_op      = OP_SET_SIZE;
        code_arg     = '0;
        spikes_in    = '0;
        spikes_valid = 1'b0;
        @(negedge s_rst);

        begin_test("frame_16x8");
        configure(16, 8);
        set_weights(1'b1, '0);
        fill_frame(16, 8, 1'b0);
        run_frame(16, 8, 1'b0);
        end_test();

        begin_test("frame_done_timing");      // Second frame on the same setup.
        fill_frame(16, 8, 1'b0);
        run_frame(16, 8, 1'b0);
        end_test();

        begin_test("reconfig_7x5");
        configure(7, 5);
        set_weights(1'b1, '0);
        fill_frame(7, 5, 1'b0);
        run_frame(7, 5, 1'b0);
        end_test();

        begin_test("gapped_input");
        configure(16, 8);
        set_weights(1'b1, '0);
        fill_frame(16, 8, 1'b0);
        run_frame(16, 8, 1'b0);
        run_frame(16, 8, 1'b1);               // Same frame again with idle cycles.
        end_test();

        begin_test("signed_extremes");
        configure(7, 5);
        fill_frame(7, 5, 1'b1);
        set_weights(1'b0, weight_t'(-8));
        uniform_exp = psum_t'(-72);           // Nine taps at minus 8.
        uniform_chk = 1'b1;
        run_frame(7, 5, 1'b0);
        set_weights(1'b0, weight_t'(7));
        uniform_exp = psum_t'(63);            // Nine taps at plus 7.
        run_frame(7, 5, 1'b0);
        uniform_chk = 1'b0;
        end_test();

        begin_test("reset_mid_frame");
        configure(16, 8);
        set_weights(1'b1, '0);
        fill_frame(16, 8, 1'b0);
        start_frame(16, 8);
        drive_lines(16, 4, 1'b0);
        while (psum_valid !== 1'b1) @(negedge s_clk);
        @(posedge s_clk);
        #1;
        rst_req = 1'b1;
        #1;
        check_flag("psum_valid during reset", 1'b0, psum_valid);
        repeat (2) @(posedge s_clk);
        #1;
        rst_req = 1'b0;
        configure(16, 8);
        set_weights(1'b1, '0);
        fill_frame(16, 8, 1'b0);
        run_frame(16, 8, 1'b0);
        end_test();

        $display("Tests: %0d, outputs: %0d, checks: %0d, errors: %0d", n_tests, n_total,
                 checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns while waiting for outputs.", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// Testbench clock and reset source with a 10 ns clock, a 2-cycle power-on reset and a reset request input.
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    input  wire  i_rst_req,    // Holds reset high while set.
    output logic o_clk,
    output logic o_rst
);

    logic por;

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    initial begin
        por = 1'b1;
        repeat (2) @(posedge o_clk);
        #1 por = 1'b0;
    end

    assign o_rst = por | i_rst_req;

endmodule

`default_nettype wire

/* snn_conv_top.sv */
// Top level of the spiking convolution input stage; connects control, line packer, ring buffer and conv.
`timescale 1ns/1ps
`default_nettype none
`include "snn_params.svh"

module snn_conv_top
    import snn_pkg::*;
(
    input  wire                             s_clk,
    input  wire                             s_rst,
    input  wire                             i_code_valid,
    input  wire code_op_e                   i_code_op,
    input  wire [15:0]                      i_code_arg,
    input  wire spike_t                     i_spikes_in,
    input  wire                             i_spikes_valid,
    output logic                            o_psum_valid,
    output logic [`TIME_STEPS*`PSUM_W-1:0]  o_psum,
    output size_t                           o_out_row,
    output size_t                           o_out_col,
    output logic                            o_frame_done
);

    size_t      img_width;
    logic       size_load;
    logic       line_valid;
    line_t      line_data;
    line_t      row_top;
    line_t      row_mid;
    line_t      row_bot;
    logic       wt_we;
    logic [3:0] wt_idx;
    weight_t    wt_val;
    logic       win_valid;
    size_t      win_col;
    size_t      win_row;
    logic       win_last;

    conv_layer_ctrl u_ctrl (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_code_valid (i_code_valid),
        .i_code_op    (i_code_op),
        .i_code_arg   (i_code_arg),
        .i_line_valid (line_valid),
        .o_img_width  (img_width),
        .o_size_load  (size_load),
        .o_wt_we      (wt_we),
        .o_wt_idx     (wt_idx),
        .o_wt_val     (wt_val),
        .o_win_valid  (win_valid),
        .o_win_col    (win_col),
        .o_win_row    (win_row),
        .o_win_last   (win_last)
    );

    organize_data_unit u_pack (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_img_width    (img_width),
        .i_size_load    (size_load),
        .i_spikes_in    (i_spikes_in),
        .i_spikes_valid (i_spikes_valid),
        .o_line_valid   (line_valid),
        .o_line_data    (line_data)
    );

    line_ring_buffer u_lines (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_line_valid (line_valid),
        .i_line_data  (line_data),
        .o_row_top    (row_top),
        .o_row_mid    (row_mid),
        .o_row_bot    (row_bot)
    );

    spike_window_conv u_conv (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_wt_we      (wt_we),
        .i_wt_idx     (wt_idx),
        .i_wt_val     (wt_val),
        .i_win_valid  (win_valid),
        .i_win_col    (win_col),
        .i_win_row    (win_row),
        .i_win_last   (win_last),
        .i_row_top    (row_top),
        .i_row_mid    (row_mid),
        .i_row_bot    (row_bot),
        .o_psum_valid (o_psum_valid),
        .o_psum       (o_psum),
        .o_out_row    (o_out_row),
        .o_out_col    (o_out_col),
        .o_frame_done (o_frame_done)
    );

endmodule

`default_nettype wire

/* conv_layer_ctrl.sv */
// Decodes configuration commands, counts lines and columns, and runs the column sweep FSM.
`timescale 1ns/1ps
`default_nettype none
`include "snn_params.svh"

module conv_layer_ctrl
    import snn_pkg::*;
(
    input  wire           s_clk,
    input  wire           s_rst,
    input  wire           i_code_valid,
    input  wire code_op_e i_code_op,
    input  wire [15:0]    i_code_arg,
    input  wire           i_line_valid,    // One pulse per completed line.
    output size_t         o_img_width,
    output logic          o_size_load,
    output logic          o_wt_we,
    output logic [3:0]    o_wt_idx,
    output weight_t       o_wt_val,
    output logic          o_win_valid,
    output size_t         o_win_col,
    output size_t         o_win_row,
    output logic          o_win_last
);

    ctrl_state_e state;
    size_t       img_width;
    size_t       img_height;
    size_t       line_cnt;     // Lines received so far in this frame.
    size_t       col_cnt;
    size_t       row_cnt;
    logic        last_row;     // The current sweep covers the bottom rows of the frame.
    logic        size_cmd;
    logic        last_line;
    logic        col_end;

    assign size_cmd    = i_code_valid && (i_code_op == OP_SET_SIZE);
    assign o_size_load = size_cmd;
    assign o_img_width = img_width;
    assign o_wt_we     = i_code_valid && (i_code_op == OP_SET_WEIGHT);
    assign o_wt_idx    = i_code_arg[7:4];
    assign o_wt_val    = weight_t'(i_code_arg[3:0]);

    assign last_line   = (line_cnt == img_height - 1'b1);
    assign col_end     = (col_cnt == img_width - 2'd3);
    assign o_win_valid = (state == ST_SWEEP);
    assign o_win_col   = col_cnt;
    assign o_win_row   = row_cnt;
    assign o_win_last  = o_win_valid && last_row && col_end;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            img_width  <= '0;
            img_height <= '0;
        end else if (size_cmd) begin
            img_width  <= i_code_arg[`IMG_SIZE_W-1:0];
            img_height <= i_code_arg[8 +: `IMG_SIZE_W];
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state    <= ST_IDLE;
            line_cnt <= '0;
            col_cnt  <= '0;
            row_cnt  <= '0;
            last_row <= 1'b0;
        end else if (size_cmd) begin
            state    <= ST_IDLE;       // A new size starts a fresh frame.
            line_cnt <= '0;
            col_cnt  <= '0;
        end else begin
            if (i_line_valid) begin
                line_cnt <= last_line ? '0 : line_cnt + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (i_line_valid) begin
                        state <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (i_line_valid && (line_cnt >= size_t'(2))) begin
                        state    <= ST_SWEEP;
                        col_cnt  <= '0;
                        row_cnt  <= line_cnt - 2'd2;   // Top row of the window.
                        last_row <= last_line;
                    end
                end
                ST_SWEEP: begin
                    if (col_end) begin
                        state   <= last_row ? ST_IDLE : ST_FILL;
                        col_cnt <= '0;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // The sweep must finish before the next line completes.
    a_no_line_in_sweep: assert property (@(posedge s_clk) disable iff (s_rst)
        i_line_valid |-> (state != ST_SWEEP))
        else $error("Line pulse arrived during a column sweep.");

endmodule

`default_nettype wire

/* spike_window_conv.sv */
// Holds the nine kernel weights and registers the per-time-step 3x3 partial sums of one window.
`timescale 1ns/1ps
`default_nettype none
`include "snn_params.svh"

module spike_window_conv
    import snn_pkg::*;
(
    input  wire                                 s_clk,
    input  wire                                 s_rst,
    input  wire                                 i_wt_we,
    input  wire [3:0]                           i_wt_idx,    // Row-major tap index 0 to 8.
    input  wire weight_t                        i_wt_val,
    input  wire                                 i_win_valid,
    input  wire size_t                          i_win_col,   // Leftmost column of the window.
    input  wire size_t                          i_win_row,
    input  wire                                 i_win_last,
    input  wire line_t                          i_row_top,
    input  wire line_t                          i_row_mid,
    input  wire line_t                          i_row_bot,
    output logic                                o_psum_valid,
    output logic [`TIME_STEPS*`PSUM_W-1:0]      o_psum,      // Time step 0 in the lowest slot.
    output size_t                               o_out_row,
    output size_t                               o_out_col,
    output logic                                o_frame_done
);

    weight_t wt_mem [9];
    spike_t  taps   [9];
    psum_t   sums   [`TIME_STEPS];

    // Gather the 3x3 window in the same row-major order as the weights.
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            taps[c]     = i_row_top[i_win_col + size_t'(c)];
            taps[3 + c] = i_row_mid[i_win_col + size_t'(c)];
            taps[6 + c] = i_row_bot[i_win_col + size_t'(c)];
        end
    end

    always_comb begin
        for (int t = 0; t < `TIME_STEPS; t++) begin
            sums[t] = '0;
            for (int k = 0; k < 9; k++) begin
                if (taps[k][t]) begin
                    sums[t] = sums[t] + psum_t'(wt_mem[k]);  // Sign extends the weight.
                end
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            for (int k = 0; k < 9; k++) begin
                wt_mem[k] <= '0;
            end
            o_psum_valid <= 1'b0;
            o_frame_done <= 1'b0;
            o_out_row    <= '0;
            o_out_col    <= '0;
        end else begin
            if (i_wt_we && (i_wt_idx < 4'd9)) begin
                wt_mem[i_wt_idx] <= i_wt_val;
            end
            o_psum_valid <= i_win_valid;
            o_frame_done <= i_win_valid && i_win_last;
            if (i_win_valid) begin
                o_out_row <= i_win_row;
                o_out_col <= i_win_col;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_win_valid) begin
            for (int t = 0; t < `TIME_STEPS; t++) begin
                o_psum[t*`PSUM_W +: `PSUM_W] <= sums[t];
            end
        end
    end

    // The index is decoded upstream from the command argument.
    a_wt_idx: assert property (@(posedge s_clk) disable iff (s_rst)
        i_wt_we |-> (i_wt_idx < 4'd9))
        else $error("Weight write with index above 8.");

endmodule

`default_nettype wire

/* line_ring_buffer.sv */
// Three-slot rotating line store that presents the three newest lines as top, middle and bottom rows.
`timescale 1ns/1ps
`default_nettype none
`include "snn_params.svh"

module line_ring_buffer
    import snn_pkg::*;
(
    input  wire        s_clk,
    input  wire        s_rst,
    input  wire        i_line_valid,
    input  wire line_t i_line_data,
    output line_t      o_row_top,    // Oldest of the three lines.
    output line_t      o_row_mid,
    output line_t      o_row_bot     // Newest line.
);

    line_t      line_mem [3];
    logic [1:0] wr_ptr;     // Slot that the next line overwrites, which holds the oldest line.

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_ptr <= 2'd0;
        end else if (i_line_valid) begin
            if (wr_ptr == 2'd2) begin
                wr_ptr <= 2'd0;
            end else begin
                wr_ptr <= wr_ptr + 2'd1;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_line_valid) begin
            line_mem[wr_ptr] <= i_line_data;
        end
    end

    // Rows rotate with the pointer so the newest line always lands at the bottom.
    always_comb begin
        case (wr_ptr)
            2'd0: begin
                o_row_top = line_mem[0];
                o_row_mid = line_mem[1];
                o_row_bot = line_mem[2];
            end
            2'd1: begin
                o_row_top = line_mem[1];
                o_row_mid = line_mem[2];
                o_row_bot = line_mem[0];
            end
            2'd2: begin
                o_row_top = line_mem[2];
                o_row_mid = line_mem[0];
                o_row_bot = line_mem[1];
            end
            default: begin
                o_row_top = '0;
                o_row_mid = '0;
                o_row_bot = '0;
            end
        endcase
    end

    a_ptr_range: assert property (@(posedge s_clk) disable iff (s_rst)
        wr_ptr != 2'd3)
        else $error("Ring buffer write pointer left the three slots.");

endmodule

`default_nettype wire

/* organize_data_unit.sv */
// Packs per-pixel spike vectors into one image line and pulses when the line is complete.
`timescale 1ns/1ps
`default_nettype none
`include "snn_params.svh"

module organize_data_unit
    import snn_pkg::*;
(
    input  wire         s_clk,
    input  wire         s_rst,
    input  wire size_t  i_img_width,     // Configured line width in pixels.
    input  wire         i_size_load,     // Size command restarts the line.
    input  wire spike_t i_spikes_in,
    input  wire         i_spikes_valid,
    output logic        o_line_valid,
    output line_t       o_line_data
);

    size_t pix_cnt;    // Slot of the next incoming pixel.
    logic  last_pix;
    line_t line_reg;

    assign last_pix    = (pix_cnt == i_img_width - 1'b1);
    assign o_line_data = line_reg;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            pix_cnt <= '0;
        end else if (i_size_load) begin
            pix_cnt <= '0;
        end else if (i_spikes_valid) begin
            if (last_pix) begin
                pix_cnt <= '0;                 // Wrap after the last pixel of the line.
            end else begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_line_valid <= 1'b0;
        end else begin
            o_line_valid <= i_spikes_valid && last_pix && !i_size_load;
        end
    end

    // Pixel 0 clears the rest so slots past the width read as zero.
    always_ff @(posedge s_clk) begin
        if (i_spikes_valid) begin
            for (int k = 0; k < `IMG_WIDTH; k++) begin
                if (pix_cnt == size_t'(k)) begin
                    line_reg[k] <= i_spikes_in;
                end else if (pix_cnt == '0) begin
                    line_reg[k] <= '0;
                end
            end
        end
    end

    // The width comes from the controller and must allow at least one window.
    a_width_min: assert property (@(posedge s_clk) disable iff (s_rst)
        i_spikes_valid |-> (i_img_width >= size_t'(3)))
        else $error("Pixel strobe while the image width is below 3.");

endmodule

`default_nettype wire

/* snn_pkg.sv */
// Shared enums and typedefs for the spiking convolution stage; import it where the types are used.
`default_nettype none
`include "snn_params.svh"

package snn_pkg;

    // Command opcodes on the configuration port.
    typedef enum logic {
        OP_SET_SIZE   = 1'b0,  // Low byte is the width and high byte the height.
        OP_SET_WEIGHT = 1'b1   // Bits 7 to 4 select the tap and bits 3 to 0 hold the weight.
    } code_op_e;

    // States of the column sweep FSM.
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_FILL  = 2'd1,
        ST_SWEEP = 2'd2
    } ctrl_state_e;

    typedef logic [`TIME_STEPS-1:0]           spike_t;   // Bit t is the spike of time step t.
    typedef spike_t [`IMG_WIDTH-1:0]          line_t;    // Pixel 0 sits in the lowest slot.
    typedef logic signed [`WT_W-1:0]          weight_t;
    typedef logic signed [`PSUM_W-1:0]        psum_t;
    typedef logic [`IMG_SIZE_W-1:0]           size_t;

endpackage

`default_nettype wire

/* snn_params.svh */
// Size macros for the spiking convolution input stage, included by every RTL file and the testbench.
`ifndef SNN_PARAMS_SVH
`define SNN_PARAMS_SVH

// Time steps per pixel, which is also the bit count of one spike vector.
`define TIME_STEPS 4

// Largest supported line in pixels.
`define IMG_WIDTH 16

// Bit width of the width, height, row and column counts.
`define IMG_SIZE_W 5

// Width of one signed kernel weight.
`define WT_W 4

// Width of one signed partial sum. Nine taps at minus 8 give minus 72.
`define PSUM_W 8

`endif
